//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int XLEN = 16;
	localparam int REG_AW = 3;
	localparam int NUM_REGS = 8;

	// Instruction fields, MSB of each
	localparam int OP_MSB = 15;
	localparam int RD_MSB = 11;
	localparam int RS_MSB = 8;
	localparam int RT_MSB = 5;
	localparam int IMM8_W = 8;
	localparam int IMM6_W = 6;

	typedef enum logic [3:0] {
		OP_LI   = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SLL  = 4'h6,
		OP_SLT  = 4'h7,
		OP_LW   = 4'h8,
		OP_SW   = 4'h9,
		OP_BEQZ = 4'ha,
		OP_HALT = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SLT,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		S_FETCH,
		S_DECODE,
		S_EXEC,
		S_MEM,
		S_WB,
		S_HALT
	} state_e;

endpackage

`default_nettype wire

//--- mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;
	import cpu_pkg::*;

	logic            req;
	logic            write;
	logic [XLEN-1:0] addr;
	logic [XLEN-1:0] wdata;
	logic [XLEN-1:0] rdata;
	logic            done;

	modport ctrl (
		output req, write, addr, wdata,
		input  rdata, done
	);

	modport bus (
		input  req, write, addr, wdata,
		output rdata, done
	);

endinterface

`default_nettype wire

//--- core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module core_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	mem_req_if.ctrl                    mem,
	output logic [cpu_pkg::REG_AW-1:0] rs_addr,
	output logic [cpu_pkg::REG_AW-1:0] rt_addr,
	output logic [cpu_pkg::REG_AW-1:0] rd_addr,
	input  logic [cpu_pkg::XLEN-1:0]   rs_data,
	input  logic [cpu_pkg::XLEN-1:0]   rt_data,
	output logic                       wr_en,
	output logic [cpu_pkg::XLEN-1:0]   wr_data,
	output cpu_pkg::alu_op_e           alu_op,
	output logic [cpu_pkg::XLEN-1:0]   alu_a,
	output logic [cpu_pkg::XLEN-1:0]   alu_b,
	input  logic [cpu_pkg::XLEN-1:0]   alu_y,
	input  logic                       alu_zero,
	output logic                       halted
);
	import cpu_pkg::*;

	state_e          state;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] ir;
	logic [XLEN-1:0] res_q;
	logic            req_q;
	opcode_e         opcode;
	logic            writes_rd;
	logic            is_mem;

	assign opcode = opcode_e'(ir[OP_MSB -: 4]);

	always_comb begin
		alu_op = ALU_PASS_B;
		alu_b = rt_data;
		writes_rd = 1'b1;
		is_mem = 1'b0;
		case (opcode)
			OP_LI:   alu_b = {{(XLEN-IMM8_W){1'b0}}, ir[IMM8_W-1:0]};
			OP_ADD:  alu_op = ALU_ADD;
			OP_SUB:  alu_op = ALU_SUB;
			OP_AND:  alu_op = ALU_AND;
			OP_OR:   alu_op = ALU_OR;
			OP_XOR:  alu_op = ALU_XOR;
			OP_SLL:  alu_op = ALU_SLL;
			OP_SLT:  alu_op = ALU_SLT;
			OP_LW, OP_SW: begin
				alu_op = ALU_ADD;
				alu_b = {{(XLEN-IMM6_W){1'b0}}, ir[IMM6_W-1:0]};
				writes_rd = (opcode == OP_LW);
				is_mem = 1'b1;
			end
			// Zero test of rd goes through the pass path
			default: writes_rd = 1'b0;
		endcase
	end

	assign rs_addr = ir[RS_MSB -: REG_AW];
	assign rd_addr = ir[RD_MSB -: REG_AW];
	// Store data and branch test both read rd on the second port
	assign rt_addr = (opcode == OP_SW || opcode == OP_BEQZ) ? rd_addr : ir[RT_MSB -: REG_AW];
	assign alu_a = rs_data;

	assign wr_en = (state == S_WB) && writes_rd;
	assign wr_data = res_q;
	assign halted = (state == S_HALT);

	assign mem.req = req_q;
	assign mem.write = (state == S_MEM) && (opcode == OP_SW);
	assign mem.addr = (state == S_MEM) ? res_q : pc;
	assign mem.wdata = rt_data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_FETCH;
			pc <= '0;
			ir <= '0;
			req_q <= 1'b0;
		end else begin
			case (state)
				S_FETCH: begin
					if (mem.done) begin
						req_q <= 1'b0;
						ir <= mem.rdata;
						pc <= pc + 1'b1;
						state <= S_DECODE;
					end else begin
						req_q <= 1'b1;
					end
				end
				S_DECODE: begin
					case (opcode)
						OP_LI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SLT,
						OP_LW, OP_SW, OP_BEQZ: state <= S_EXEC;
						default: state <= S_HALT;
					endcase
				end
				S_EXEC: begin
					if (opcode == OP_BEQZ) begin
						if (alu_zero)
							pc <= pc + {{(XLEN-IMM8_W){ir[IMM8_W-1]}}, ir[IMM8_W-1:0]};
						state <= S_FETCH;
					end else begin
						state <= is_mem ? S_MEM : S_WB;
					end
				end
				S_MEM: begin
					if (mem.done) begin
						req_q <= 1'b0;
						state <= S_WB;
					end else begin
						req_q <= 1'b1;
					end
				end
				S_WB:    state <= S_FETCH;
				default: state <= S_HALT;
			endcase
		end
	end

	// Execute result, replaced by load data at the end of a read
	always_ff @(posedge clk) begin
		if (state == S_EXEC)
			res_q <= alu_y;
		else if (state == S_MEM && mem.done && !mem.write)
			res_q <= mem.rdata;
	end

	a_no_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
		mem.req |-> !(state inside {S_DECODE, S_HALT}));

	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		mem.req && !mem.done |=> mem.req && $stable(mem.addr) && $stable(mem.write));

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [cpu_pkg::REG_AW-1:0] rs_addr,
	input  logic [cpu_pkg::REG_AW-1:0] rt_addr,
	input  logic [cpu_pkg::REG_AW-1:0] wr_addr,
	output logic [cpu_pkg::XLEN-1:0]   rs_data,
	output logic [cpu_pkg::XLEN-1:0]   rt_data,
	input  logic                       wr_en,
	input  logic [cpu_pkg::XLEN-1:0]   wr_data
);
	import cpu_pkg::*;

	// r0 has no storage
	logic [XLEN-1:0] regs [1:NUM_REGS-1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::alu_op_e         op,
	input  logic [cpu_pkg::XLEN-1:0] a,
	input  logic [cpu_pkg::XLEN-1:0] b,
	output logic [cpu_pkg::XLEN-1:0] y,
	output logic                     zero
);
	import cpu_pkg::*;

	logic lt;

	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ALU_ADD:    y = a + b;
			ALU_SUB:    y = a - b;
			ALU_AND:    y = a & b;
			ALU_OR:     y = a | b;
			ALU_XOR:    y = a ^ b;
			// Shift amount is the low nibble only
			ALU_SLL:    y = a << b[3:0];
			ALU_SLT:    y = {{(XLEN-1){1'b0}}, lt};
			ALU_PASS_B: y = b;
			default:    y = b;
		endcase
	end

	assign zero = (y == '0);

endmodule

`default_nettype wire

//--- apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module apb_master (
	input  logic                     clk,
	input  logic                     rst_n,
	mem_req_if.bus                   mem,
	output logic                     psel,
	output logic                     penable,
	output logic                     pwrite,
	output logic [cpu_pkg::XLEN-1:0] paddr,
	output logic [cpu_pkg::XLEN-1:0] pwdata,
	input  logic [cpu_pkg::XLEN-1:0] prdata,
	input  logic                     pready
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		A_IDLE,
		A_SETUP,
		A_ACCESS
	} apb_state_e;

	apb_state_e state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= A_IDLE;
		end else begin
			case (state)
				A_IDLE:   if (mem.req) state <= A_SETUP;
				A_SETUP:  state <= A_ACCESS;
				A_ACCESS: if (pready) state <= A_IDLE;
				default:  state <= A_IDLE;
			endcase
		end
	end

	// Captured once per transfer, held through the access phase
	always_ff @(posedge clk) begin
		if (state == A_IDLE && mem.req) begin
			paddr <= mem.addr;
			pwrite <= mem.write;
			pwdata <= mem.wdata;
		end
	end

	assign psel = (state != A_IDLE);
	assign penable = (state == A_ACCESS);

	assign mem.done = (state == A_ACCESS) && pready;
	assign mem.rdata = prdata;

	a_enable_sel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel && $past(psel));

	a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		psel && !(penable && pready) |=> psel && $stable(paddr) && $stable(pwrite));

endmodule

`default_nettype wire

//--- cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  logic                     clk,
	input  logic                     rst_n,
	output logic                     psel,
	output logic                     penable,
	output logic                     pwrite,
	output logic [cpu_pkg::XLEN-1:0] paddr,
	output logic [cpu_pkg::XLEN-1:0] pwdata,
	input  logic [cpu_pkg::XLEN-1:0] prdata,
	input  logic                     pready,
	output logic                     halted
);
	import cpu_pkg::*;

	logic [REG_AW-1:0] rs_addr;
	logic [REG_AW-1:0] rt_addr;
	logic [REG_AW-1:0] rd_addr;
	logic [XLEN-1:0]   rs_data;
	logic [XLEN-1:0]   rt_data;
	logic              wr_en;
	logic [XLEN-1:0]   wr_data;
	alu_op_e           alu_op;
	logic [XLEN-1:0]   alu_a;
	logic [XLEN-1:0]   alu_b;
	logic [XLEN-1:0]   alu_y;
	logic              alu_zero;

	mem_req_if mem_bus ();

	core_ctrl __core_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.mem(mem_bus.ctrl),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rd_addr(rd_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.alu_y(alu_y),
		.alu_zero(alu_zero),
		.halted(halted)
	);

	reg_file __reg_file (
		.clk(clk),
		.rst_n(rst_n),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.wr_addr(rd_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.wr_en(wr_en),
		.wr_data(wr_data)
	);

	alu __alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.y(alu_y),
		.zero(alu_zero)
	);

	apb_master __apb_master (
		.clk(clk),
		.rst_n(rst_n),
		.mem(mem_bus.bus),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;
	import cpu_pkg::*;

	localparam int PERIOD = 100;
	localparam int MEM_WORDS = 256;
	localparam int NUM_ROWS = 15;
	// Worst case row, fourteen words at seventeen cycles, plus reset
	localparam int ROW_CYCLES = 300;
	localparam int WATCHDOG_NS = NUM_ROWS * ROW_CYCLES * PERIOD;

	logic            clk;
	logic            rst_n;
	logic            psel;
	logic            penable;
	logic            pwrite;
	logic [XLEN-1:0] paddr;
	logic [XLEN-1:0] pwdata;
	logic [XLEN-1:0] prdata;
	logic            pready;
	logic            halted;

	logic [XLEN-1:0] mem [0:MEM_WORDS-1];
	logic [XLEN-1:0] prog [$];
	opcode_e         row_op [0:NUM_ROWS-1];
	logic [XLEN-1:0] row_a [0:NUM_ROWS-1];
	logic [XLEN-1:0] row_b [0:NUM_ROWS-1];
	logic            row_br [0:NUM_ROWS-1];
	logic [XLEN-1:0] row_exp [0:NUM_ROWS-1];
	int              n_rows = 0;
	integer          seed = 41;
	int              wait_cnt = 0;
	int              errors = 0;
	int              checks = 0;
	logic            prev_psel = 1'b0;
	logic            prev_penable = 1'b0;
	logic            prev_pready = 1'b0;
	logic            prev_pwrite = 1'b0;
	logic [XLEN-1:0] prev_paddr = '0;
	logic [XLEN-1:0] prev_pwdata = '0;

	cpu_top dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the core did not halt in time", $time);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [XLEN-1:0] fill_word(input int addr);
		return 16'hf000 | 16'(addr);
	endfunction

	function automatic logic [XLEN-1:0] enc_r(input opcode_e op, input logic [2:0] rd,
			input logic [2:0] rs, input logic [2:0] rt);
		return {op, rd, rs, rt, 3'b000};
	endfunction

	function automatic logic [XLEN-1:0] enc_i(input opcode_e op, input logic [2:0] rd,
			input logic [7:0] imm8);
		return {op, rd, 1'b0, imm8};
	endfunction

	function automatic logic [XLEN-1:0] enc_m(input opcode_e op, input logic [2:0] rd,
			input logic [2:0] rs, input logic [5:0] imm6);
		return {op, rd, rs, imm6};
	endfunction

	task automatic add_row(input opcode_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic br, input logic [XLEN-1:0] exp);
		row_op[n_rows] = op;
		row_a[n_rows] = a;
		row_b[n_rows] = b;
		row_br[n_rows] = br;
		row_exp[n_rows] = exp;
		n_rows++;
	endtask

	task automatic fill_table();
		add_row(OP_ADD, 16'h1234, 16'h0fcd, 1'b0, 16'h2201);
		add_row(OP_ADD, 16'hffff, 16'h0002, 1'b0, 16'h0001);
		add_row(OP_SUB, 16'h0005, 16'h0007, 1'b0, 16'hfffe);
		add_row(OP_AND, 16'hf0f0, 16'h3c3c, 1'b0, 16'h3030);
		add_row(OP_OR, 16'hf000, 16'h000f, 1'b0, 16'hf00f);
		add_row(OP_XOR, 16'haaaa, 16'h0ff0, 1'b0, 16'ha55a);
		add_row(OP_SLL, 16'h0001, 16'h000f, 1'b0, 16'h8000);
		add_row(OP_SLL, 16'h1234, 16'h0013, 1'b0, 16'h91a0);
		add_row(OP_SLT, 16'hfffe, 16'h0003, 1'b0, 16'h0001);
		add_row(OP_SLT, 16'h0003, 16'hfffe, 1'b0, 16'h0000);
		add_row(OP_SLT, 16'h8000, 16'hffff, 1'b0, 16'h0001);
		// Store, load back, store again
		add_row(OP_LW, 16'hbeef, 16'h0000, 1'b0, 16'hbeef);
		// Branch rows, b is the marker
		add_row(OP_BEQZ, 16'h0000, 16'h0055, 1'b1, 16'h0055);
		add_row(OP_BEQZ, 16'h0100, 16'h0055, 1'b0, 16'h0055);
		// Writes aimed at r0
		add_row(OP_LI, 16'h12ab, 16'h0000, 1'b0, 16'h0000);
	endtask

	// Upper byte by LI and shift by eight, r7 as scratch
	task automatic load_const(input logic [2:0] r, input logic [XLEN-1:0] v);
		if (v[15:8] == 8'h00) begin
			prog.push_back(enc_i(OP_LI, r, v[7:0]));
		end else begin
			prog.push_back(enc_i(OP_LI, r, v[15:8]));
			prog.push_back(enc_i(OP_LI, 3'd7, 8'd8));
			prog.push_back(enc_r(OP_SLL, r, r, 3'd7));
			if (v[7:0] != 8'h00) begin
				prog.push_back(enc_i(OP_LI, 3'd7, v[7:0]));
				prog.push_back(enc_r(OP_OR, r, r, 3'd7));
			end
		end
	endtask

	task automatic build_program(input int idx);
		prog.delete();
		prog.push_back(enc_i(OP_LI, 3'd6, 8'(200 + idx)));
		case (row_op[idx])
			OP_LI: begin
				load_const(3'd0, row_a[idx]);
				prog.push_back(enc_m(OP_SW, 3'd0, 3'd6, 6'd0));
			end
			OP_LW: begin
				load_const(3'd1, row_a[idx]);
				prog.push_back(enc_m(OP_SW, 3'd1, 3'd6, 6'd0));
				prog.push_back(enc_m(OP_LW, 3'd4, 3'd6, 6'd0));
				prog.push_back(enc_i(OP_LI, 3'd5, 8'(150 + idx)));
				prog.push_back(enc_m(OP_SW, 3'd4, 3'd5, 6'd0));
			end
			OP_BEQZ: begin
				load_const(3'd1, row_a[idx]);
				load_const(3'd2, row_b[idx]);
				prog.push_back(enc_i(OP_BEQZ, 3'd1, 8'd1));
				prog.push_back(enc_m(OP_SW, 3'd2, 3'd6, 6'd0));
			end
			default: begin
				load_const(3'd1, row_a[idx]);
				load_const(3'd2, row_b[idx]);
				prog.push_back(enc_r(row_op[idx], 3'd3, 3'd1, 3'd2));
				prog.push_back(enc_m(OP_SW, 3'd3, 3'd6, 6'd0));
			end
		endcase
		prog.push_back(enc_i(OP_HALT, 3'd0, 8'd0));
	endtask

	task automatic check_quiet();
		checks++;
		assert (!psel && !penable && !halted) else begin
			errors++;
			$display("bus or halted active around reset at %0t", $time);
		end
	endtask

	task automatic check_word(input int idx, input int addr, input logic [XLEN-1:0] exp);
		checks++;
		assert (mem[addr] === exp) else begin
			errors++;
			$display("mismatch at %0t: row %0d word %0d holds %h, expected %h",
				$time, idx, addr, mem[addr], exp);
		end
	endtask

	task automatic run_row(input int idx);
		logic [XLEN-1:0] exp;
		build_program(idx);
		@(negedge clk);
		rst_n = 1'b0;
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = fill_word(a);
		foreach (prog[i])
			mem[i] = prog[i];
		repeat (3) begin
			@(negedge clk);
			check_quiet();
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_quiet();
		while (!halted)
			@(negedge clk);
		// Window for stray transfers after halt
		repeat (4) @(negedge clk);
		if (row_op[idx] == OP_BEQZ && row_br[idx])
			exp = fill_word(200 + idx);
		else
			exp = row_exp[idx];
		check_word(idx, 200 + idx, exp);
		if (row_op[idx] == OP_LW)
			check_word(idx, 150 + idx, exp);
	endtask

	// APB memory and protocol monitor
	always @(negedge clk) begin
		if (penable) begin
			checks++;
			assert (psel && prev_psel && !(prev_penable && prev_pready)
				&& paddr == prev_paddr && pwrite == prev_pwrite && pwdata == prev_pwdata)
			else begin
				errors++;
				$display("access phase at %0t did not follow a held setup phase", $time);
			end
			assert (paddr < MEM_WORDS) else begin
				errors++;
				$display("APB address %h out of range at %0t", paddr, $time);
			end
		end
		assert (!(halted && psel)) else begin
			errors++;
			$display("APB transfer after halt at %0t", $time);
		end
		prev_psel = psel;
		prev_penable = penable;
		prev_pready = pready;
		prev_pwrite = pwrite;
		prev_paddr = paddr;
		prev_pwdata = pwdata;
		if (psel && !penable) begin
			wait_cnt = $random(seed) & 3;
			pready = 1'b0;
		end else if (psel && penable && wait_cnt == 0) begin
			pready = 1'b1;
			if (pwrite)
				mem[paddr[7:0]] = pwdata;
			else
				prdata = mem[paddr[7:0]];
		end else begin
			if (psel)
				wait_cnt--;
			pready = 1'b0;
		end
	end

	initial begin
		rst_n = 1'b0;
		pready = 1'b0;
		prdata = '0;
		fill_table();
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
cpu_pkg.sv
mem_req_if.sv
core_ctrl.sv
reg_file.sv
alu.sv
apb_master.sv
cpu_top.sv
tb_cpu.sv
